// ==== all.f ====
+incdir+common
common/soc_pkg.sv
design/wb_arbiter2.sv
design/wb_decoder.sv
ram/wb_ram.sv
design/wb_gpio.sv
design/soc_fabric_top.sv
verification/tb_soc_fabric.sv

// ==== common/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Address map

// Word RAM region
`define RAM_ADDR    32'h0000_0000
`define RAM_SIZE    32'd1024

// GPIO register block, four word registers
`define GPIO_ADDR   32'h1000_0000
`define GPIO_SIZE   32'd16

//////////////////////////////////////////////////////////////////////
// Peripheral sizing

// Number of GPIO pins
`define NGPIO       8

`endif

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus payloads

    // Master request, 71 bits
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    // Slave response, 34 bits
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Enumerations

    // Decode target on the shared bus
    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_RAM,
        DEV_GPIO
    } device_e;

    // Current owner of the shared bus
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M0,
        ARB_M1
    } arb_state_e;

    // GPIO register index, from address bits 3:2
    typedef enum logic [1:0] {
        GPIO_REG_OUT = 2'd0,
        GPIO_REG_DIR = 2'd1,
        GPIO_REG_IN  = 2'd2
    } gpio_reg_e;

endpackage

`default_nettype wire

// ==== design/soc_fabric_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_fabric_top (
    input  wire                   clk_i,
    input  wire                   rst_n_i,

    // Instruction port of the core
    input  wire soc_pkg::wb_req_t m0_req_i,
    output soc_pkg::wb_rsp_t      m0_rsp_o,
    // Data port of the core
    input  wire soc_pkg::wb_req_t m1_req_i,
    output soc_pkg::wb_rsp_t      m1_rsp_o,

    input  wire  [`NGPIO-1:0]     gpio_in_i,
    output logic [`NGPIO-1:0]     gpio_out_o,
    output logic [`NGPIO-1:0]     gpio_oe_o
);

    // Word address bits of the RAM
    localparam int RAM_AW = $clog2(`RAM_SIZE) - 2;

    soc_pkg::wb_req_t arb_req;
    soc_pkg::wb_rsp_t arb_rsp;
    soc_pkg::wb_req_t ram_req;
    soc_pkg::wb_rsp_t ram_rsp;
    soc_pkg::wb_req_t gpio_req;
    soc_pkg::wb_rsp_t gpio_rsp;

    //////////////////////////////////////////////////////////////////////
    // Shared bus

    wb_arbiter2 u_arbiter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .m0_req_i  (m0_req_i),
        .m0_rsp_o  (m0_rsp_o),
        .m1_req_i  (m1_req_i),
        .m1_rsp_o  (m1_rsp_o),
        .bus_req_o (arb_req),
        .bus_rsp_i (arb_rsp)
    );

    wb_decoder u_decoder (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .bus_req_i  (arb_req),
        .bus_rsp_o  (arb_rsp),
        .ram_req_o  (ram_req),
        .ram_rsp_i  (ram_rsp),
        .gpio_req_o (gpio_req),
        .gpio_rsp_i (gpio_rsp)
    );

    //////////////////////////////////////////////////////////////////////
    // Slaves

    wb_ram #(
        .ADDR_WIDTH (RAM_AW)
    ) u_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    wb_gpio u_gpio (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (gpio_req),
        .rsp_o      (gpio_rsp),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o)
    );

endmodule

`default_nettype wire

// ==== design/wb_arbiter2.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter2 (
    input  wire                clk_i,
    input  wire                rst_n_i,

    input  wire soc_pkg::wb_req_t m0_req_i,
    output soc_pkg::wb_rsp_t      m0_rsp_o,
    input  wire soc_pkg::wb_req_t m1_req_i,
    output soc_pkg::wb_rsp_t      m1_rsp_o,

    output soc_pkg::wb_req_t      bus_req_o,
    input  wire soc_pkg::wb_rsp_t bus_rsp_i
);

    soc_pkg::arb_state_e state_q;
    soc_pkg::arb_state_e state_d;

    // Set when master 1 won the last contested grant
    logic m1_last_q;
    logic m1_last_d;

    //////////////////////////////////////////////////////////////////////
    // Grant selection

    always_comb begin
        state_d   = state_q;
        m1_last_d = m1_last_q;
        case (state_q)
            soc_pkg::ARB_IDLE: begin
                if (m0_req_i.cyc && m1_req_i.cyc) begin
                    // Both pending, the other one than last time wins
                    state_d   = m1_last_q ? soc_pkg::ARB_M0 : soc_pkg::ARB_M1;
                    m1_last_d = ~m1_last_q;
                end else if (m0_req_i.cyc) begin
                    state_d = soc_pkg::ARB_M0;
                end else if (m1_req_i.cyc) begin
                    state_d = soc_pkg::ARB_M1;
                end
            end
            // Owner keeps the bus until its cyc falls
            soc_pkg::ARB_M0: begin
                if (!m0_req_i.cyc) begin
                    state_d = soc_pkg::ARB_IDLE;
                end
            end
            soc_pkg::ARB_M1: begin
                if (!m1_req_i.cyc) begin
                    state_d = soc_pkg::ARB_IDLE;
                end
            end
            default: state_d = soc_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= soc_pkg::ARB_IDLE;
            m1_last_q <= 1'b1;
        end else begin
            state_q   <= state_d;
            m1_last_q <= m1_last_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request and response steering

    always_comb begin
        bus_req_o = '0;
        m0_rsp_o  = '0;
        m1_rsp_o  = '0;
        case (state_q)
            soc_pkg::ARB_M0: begin
                bus_req_o = m0_req_i;
                m0_rsp_o  = bus_rsp_i;
            end
            soc_pkg::ARB_M1: begin
                bus_req_o = m1_req_i;
                m1_rsp_o  = bus_rsp_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/wb_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module wb_decoder (
    input  wire                clk_i,
    input  wire                rst_n_i,

    input  wire soc_pkg::wb_req_t bus_req_i,
    output soc_pkg::wb_rsp_t      bus_rsp_o,

    output soc_pkg::wb_req_t      ram_req_o,
    input  wire soc_pkg::wb_rsp_t ram_rsp_i,
    output soc_pkg::wb_req_t      gpio_req_o,
    input  wire soc_pkg::wb_rsp_t gpio_rsp_i
);

    soc_pkg::device_e dev;
    logic             access;
    logic             err_q;

    assign access = bus_req_i.cyc && bus_req_i.stb;

    // Offset compare wraps below the base, so one test per region
    always_comb begin
        if ((bus_req_i.adr - `RAM_ADDR) < `RAM_SIZE) begin
            dev = soc_pkg::DEV_RAM;
        end else if ((bus_req_i.adr - `GPIO_ADDR) < `GPIO_SIZE) begin
            dev = soc_pkg::DEV_GPIO;
        end else begin
            dev = soc_pkg::DEV_NONE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Strobe routing

    always_comb begin
        ram_req_o      = bus_req_i;
        gpio_req_o     = bus_req_i;
        ram_req_o.stb  = bus_req_i.stb && (dev == soc_pkg::DEV_RAM);
        gpio_req_o.stb = bus_req_i.stb && (dev == soc_pkg::DEV_GPIO);
    end

    // Unmapped access, single error pulse like a slave ack
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= access && (dev == soc_pkg::DEV_NONE) && !err_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response mux

    always_comb begin
        case (dev)
            soc_pkg::DEV_RAM:  bus_rsp_o = ram_rsp_i;
            soc_pkg::DEV_GPIO: bus_rsp_o = gpio_rsp_i;
            default: begin
                bus_rsp_o     = '0;
                bus_rsp_o.err = err_q;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/wb_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module wb_gpio (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t      rsp_o,

    input  wire  [`NGPIO-1:0]     gpio_in_i,
    output logic [`NGPIO-1:0]     gpio_out_o,
    output logic [`NGPIO-1:0]     gpio_oe_o
);

    soc_pkg::gpio_reg_e reg_sel;
    logic               access;
    logic               ack_q;
    logic [`NGPIO-1:0]  out_q;
    logic [`NGPIO-1:0]  dir_q;
    logic [`NGPIO-1:0]  sync1_q;
    logic [`NGPIO-1:0]  sync2_q;
    logic [`NGPIO-1:0]  rd_val;
    logic [31:0]        rdata_q;

    assign reg_sel = soc_pkg::gpio_reg_e'(req_i.adr[3:2]);
    assign access  = req_i.cyc && req_i.stb && !ack_q;

    //////////////////////////////////////////////////////////////////////
    // Control registers and ack

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            out_q   <= '0;
            dir_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            ack_q   <= access;
            // Pin inputs are asynchronous
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            // Only byte 0 carries register bits
            if (access && req_i.we && req_i.sel[0]) begin
                if (reg_sel == soc_pkg::GPIO_REG_OUT) out_q <= req_i.dat[`NGPIO-1:0];
                if (reg_sel == soc_pkg::GPIO_REG_DIR) dir_q <= req_i.dat[`NGPIO-1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read path

    always_comb begin
        case (reg_sel)
            soc_pkg::GPIO_REG_OUT: rd_val = out_q;
            soc_pkg::GPIO_REG_DIR: rd_val = dir_q;
            soc_pkg::GPIO_REG_IN:  rd_val = sync2_q;
            default:               rd_val = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= {{(32-`NGPIO){1'b0}}, rd_val};
        end
    end

    assign rsp_o.dat  = rdata_q;
    assign rsp_o.ack  = ack_q;
    assign rsp_o.err  = 1'b0;
    assign gpio_out_o = out_q;
    assign gpio_oe_o  = dir_q;

endmodule

`default_nettype wire

// ==== ram/wb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  wire soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t      rsp_o
);

    logic [31:0]           mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] idx;
    logic                  access;
    logic                  ack_q;
    logic [31:0]           rdata_q;

    // Word index, byte offset dropped
    assign idx    = req_i.adr[ADDR_WIDTH+1:2];
    assign access = req_i.cyc && req_i.stb && !ack_q;

    // Byte lane writes
    always_ff @(posedge clk_i) begin
        if (access && req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.sel[i]) begin
                    mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= mem[idx];
        end
    end

    // One cycle ack, held off while already acking
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_soc_fabric -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"

// ==== verification/tb_soc_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module tb_soc_fabric;

    localparam int TIMEOUT = 50;
    localparam int NG      = `NGPIO;
    localparam int RAM_AW  = $clog2(`RAM_SIZE) - 2;
    localparam int NVEC    = 15;

    // One access and the response it should get
    typedef struct packed {
        logic        mst;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic [31:0] exp_dat;
        logic        exp_err;
    } vec_t;

    // master, we, address, write data, sel, expected read data, expected err
    // Expected data of RAM reads comes from the model instead
    localparam vec_t VECS [NVEC] = '{
        '{1'b0, 1'b1, 32'h0000_0010, 32'h1122_3344, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b1, 1'b0, 32'h0000_0010, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b1, 1'b1, 32'h0000_0010, 32'hAABB_CCDD, 4'h5, 32'h0000_0000, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0010, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b1, 1'b1, 32'h0000_03FC, 32'hDEAD_BEEF, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 1'b1, 32'h0000_03FC, 32'h0000_5A00, 4'h2, 32'h0000_0000, 1'b0},
        '{1'b1, 1'b0, 32'h0000_03FC, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 1'b1, 32'h2000_0010, 32'hFFFF_FFFF, 4'hf, 32'h0000_0000, 1'b1},
        '{1'b1, 1'b0, 32'h0000_0400, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b1},
        '{1'b0, 1'b0, 32'h0000_0010, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 1'b1, 32'h1000_0000, 32'h0000_01A5, 4'h1, 32'h0000_0000, 1'b0},
        '{1'b1, 1'b1, 32'h1000_0004, 32'hFFFF_FF3C, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b1, 1'b0, 32'h1000_0000, 32'h0000_0000, 4'hf, 32'h0000_00A5, 1'b0},
        '{1'b0, 1'b0, 32'h1000_0004, 32'h0000_0000, 4'hf, 32'h0000_003C, 1'b0},
        '{1'b0, 1'b0, 32'h1000_000C, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0}
    };

    logic             clk = 1'b0;
    logic             rst_n;
    soc_pkg::wb_req_t m0_req;
    soc_pkg::wb_req_t m1_req;
    soc_pkg::wb_rsp_t m0_rsp;
    soc_pkg::wb_rsp_t m1_rsp;
    logic [NG-1:0]    gpio_in;
    logic [NG-1:0]    gpio_out;
    logic [NG-1:0]    gpio_oe;

    logic [31:0] ram_model [2**RAM_AW];
    logic [31:0] lcg_state;
    int          err_count;
    int          tests_run;
    int          tests_failed;
    int          ack_cnt [2] = '{0, 0};

    soc_fabric_top DUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .m0_req_i   (m0_req),
        .m0_rsp_o   (m0_rsp),
        .m1_req_i   (m1_req),
        .m1_rsp_o   (m1_rsp),
        .gpio_in_i  (gpio_in),
        .gpio_out_o (gpio_out),
        .gpio_oe_o  (gpio_oe)
    );

    always #4 clk = ~clk;

    // Acks seen per master catch a doubled ack
    always @(negedge clk) begin
        if (m0_rsp.ack) ack_cnt[0]++;
        if (m1_rsp.ack) ack_cnt[1]++;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // Byte lane merge into the reference RAM
    task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel);
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) ram_model[adr[RAM_AW+1:2]][8*i +: 8] = dat[8*i +: 8];
        end
    endtask

    // One Wishbone classic cycle that counts negedges until ack or err
    task automatic bus_access(input logic mst, input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel,
                              output soc_pkg::wb_rsp_t rsp, output int cycles);
        soc_pkg::wb_req_t req;
        req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
        rsp = '0;
        cycles = 0;
        @(posedge clk);
        if (mst) begin
            m1_req <= req;
        end else begin
            m0_req <= req;
        end
        while (!rsp.ack && !rsp.err && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            rsp = mst ? m1_rsp : m0_rsp;
        end
        if (!rsp.ack && !rsp.err) begin
            $display("Master %0d saw no ack or err within %0d cycles", mst, TIMEOUT);
            err_count++;
        end
        @(posedge clk);
        if (mst) begin
            m1_req <= '0;
        end else begin
            m0_req <= '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        vec_t             v;
        soc_pkg::wb_rsp_t rsp;
        soc_pkg::wb_rsp_t rsp0;
        soc_pkg::wb_rsp_t rsp1;
        int               cycles;
        int               cyc0;
        int               cyc1;
        int               errs;
        int               n0;
        int               n1;
        logic [31:0]      exp_dat;
        logic [31:0]      a0;

        rst_n     <= 1'b0;
        m0_req    <= '0;
        m1_req    <= '0;
        gpio_in   <= '0;
        lcg_state = 32'd25;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_count;
        @(negedge clk);
        check("m0_rsp_o.ack/err", 32'h0, 32'({m0_rsp.ack, m0_rsp.err}));
        check("m1_rsp_o.ack/err", 32'h0, 32'({m1_rsp.ack, m1_rsp.err}));
        check("gpio_out_o", 32'h0, 32'(gpio_out));
        check("gpio_oe_o", 32'h0, 32'(gpio_oe));
        finish_test("reset", errs);

        for (int i = 0; i < NVEC; i++) begin
            errs = err_count;
            v = VECS[i];
            bus_access(v.mst, v.we, v.adr, v.dat, v.sel, rsp, cycles);
            exp_dat = v.exp_dat;
            if ((v.adr - `RAM_ADDR) < `RAM_SIZE && !v.exp_err) begin
                if (v.we) model_write(v.adr, v.dat, v.sel);
                exp_dat = ram_model[v.adr[RAM_AW+1:2]];
            end
            check($sformatf("m%0d_rsp_o.err", v.mst), 32'(v.exp_err), 32'(rsp.err));
            check($sformatf("m%0d_rsp_o.ack", v.mst), 32'(!v.exp_err), 32'(rsp.ack));
            if (!v.we || v.exp_err) begin
                check($sformatf("m%0d_rsp_o.dat", v.mst), exp_dat, rsp.dat);
            end
            finish_test($sformatf("vector %0d", i), errs);
        end

        errs = err_count;
        @(negedge clk);
        check("gpio_out_o", 32'h0000_00A5, 32'(gpio_out));
        check("gpio_oe_o", 32'h0000_003C, 32'(gpio_oe));
        @(posedge clk);
        gpio_in <= NG'(32'h96);
        // Two synchronizer flops plus margin
        repeat (3) @(posedge clk);
        bus_access(1'b1, 1'b0, 32'h1000_0008, 32'h0, 4'hf, rsp, cycles);
        check("m1_rsp_o.dat", 32'h0000_0096, rsp.dat);
        finish_test("gpio pins", errs);

        errs = err_count;
        bus_access(1'b0, 1'b0, 32'h0000_0010, 32'h0, 4'hf, rsp, cycles);
        check("m0_rsp_o.ack", 32'h1, 32'(rsp.ack));
        check("m0 ack latency", 32'd3, cycles);
        finish_test("idle latency", errs);

        // Words for the contention rounds are written by one master only
        for (int r = 0; r < 16; r++) begin
            a0 = 32'h100 + r * 4;
            exp_dat = lcg_next();
            bus_access(1'b0, 1'b1, a0, exp_dat, 4'hf, rsp, cycles);
            model_write(a0, exp_dat, 4'hf);
        end

        for (int r = 0; r < 8; r++) begin
            errs = err_count;
            a0 = 32'h100 + r * 8;
            n0 = ack_cnt[0];
            n1 = ack_cnt[1];
            fork
                bus_access(1'b0, 1'b0, a0, 32'h0, 4'hf, rsp0, cyc0);
                bus_access(1'b1, 1'b0, a0 + 32'd4, 32'h0, 4'hf, rsp1, cyc1);
            join
            @(negedge clk);
            check("m0_rsp_o.dat", ram_model[a0[RAM_AW+1:2]], rsp0.dat);
            check("m1_rsp_o.dat", ram_model[a0[RAM_AW+1:2] + RAM_AW'(1)], rsp1.dat);
            check("m0_rsp_o.ack count", 32'd1, ack_cnt[0] - n0);
            check("m1_rsp_o.ack count", 32'd1, ack_cnt[1] - n1);
            check("first completer", 32'(r % 2), 32'(cyc1 < cyc0));
            finish_test($sformatf("contention round %0d", r), errs);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
